// ==== tri_pkg.sv ====
package tri_pkg;

    // one data word of a beat, an index entry or a coordinate
    localparam int WORD_W = 32;
    localparam int BEAT_W = 4 * WORD_W;

    // x sits in the low word, as the controller sends it
    typedef struct packed {
        logic [WORD_W-1:0] z;
        logic [WORD_W-1:0] y;
        logic [WORD_W-1:0] x;
    } vertex_t;

    // w3 is the surface id (index phase) or the flag word (vertex phase)
    typedef struct packed {
        logic [WORD_W-1:0] w3;
        logic [WORD_W-1:0] w2;
        logic [WORD_W-1:0] w1;
        logic [WORD_W-1:0] w0;
    } load_beat_t;

    // word position of a triangle in the index RAM
    typedef enum logic [1:0] {
        slot_v0,
        slot_v1,
        slot_v2,
        slot_sid
    } index_slot_e;

    typedef enum logic [1:0] {
        ld_idle,
        ld_index_words,
        ld_vertex,
        ld_done
    } load_state_e;

    typedef enum logic [2:0] {
        f_idle,
        f_rd_v0,
        f_rd_v1,
        f_rd_v2,
        f_rd_sid,
        f_finish
    } fetch_state_e;

endpackage

// ==== tri_load_if.sv ====
`timescale 1ns/1ps

interface tri_load_if #(
    parameter int NUM_TRIANGLE = 64
);
    localparam int IDX_AW = $clog2(4 * NUM_TRIANGLE);
    localparam int VTX_AW = $clog2(4 * NUM_TRIANGLE);
    localparam int CNT_W  = $clog2(NUM_TRIANGLE + 1);

    // index RAM write port
    logic                      idx_we;
    logic [IDX_AW-1:0]         idx_addr;
    logic [tri_pkg::WORD_W-1:0] idx_data;

    // vertex lanes write port
    logic                      vtx_we;
    logic [VTX_AW-1:0]         vtx_addr;
    tri_pkg::vertex_t          vtx_data;

    // number of triangles in the scene, written at the end of the index phase
    logic                      count_we;
    logic [CNT_W-1:0]          count_val;

    modport sequencer (
        output idx_we, idx_addr, idx_data,
        output vtx_we, vtx_addr, vtx_data,
        output count_we, count_val
    );

    modport index_side (input idx_we, idx_addr, idx_data, count_we, count_val);

    modport vertex_side (input vtx_we, vtx_addr, vtx_data);

endinterface

// ==== tri_read_if.sv ====
`timescale 1ns/1ps

interface tri_read_if #(
    parameter int NUM_TRIANGLE = 64
);
    localparam int ID_W   = $clog2(NUM_TRIANGLE);
    localparam int VTX_AW = $clog2(4 * NUM_TRIANGLE);
    localparam int CNT_W  = $clog2(NUM_TRIANGLE + 1);

    // requests from the fetch unit
    logic [ID_W-1:0]            idx_rd_id;
    tri_pkg::index_slot_e       idx_rd_slot;
    logic [VTX_AW-1:0]          vtx_rd_addr;

    // data back, one cycle after the address
    logic [tri_pkg::WORD_W-1:0] idx_word;
    tri_pkg::vertex_t           vtx_word;
    logic [CNT_W-1:0]           tri_count;

    modport fetch (
        output idx_rd_id, idx_rd_slot, vtx_rd_addr,
        input  idx_word, vtx_word, tri_count
    );

    modport index_side (
        input  idx_rd_id, idx_rd_slot,
        output idx_word, tri_count
    );

    modport vertex_side (input vtx_rd_addr, output vtx_word);

endinterface

// ==== sp_ram.sv ====
`timescale 1ns/1ps

module sp_ram #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] q
);
    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];

    // read returns the old contents on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        q <= mem[addr];
    end

    // a write must land on a defined entry of the array
    a_wr_addr_known: assert property (@(posedge clk) we |-> !$isunknown(addr));

endmodule

// ==== load_sequencer.sv ====
`timescale 1ns/1ps

module load_sequencer #(
    parameter int NUM_TRIANGLE = 64
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [tri_pkg::BEAT_W-1:0] data_mc,
    input  logic                       we_mc,
    output logic                       rdy_mc,
    tri_load_if.sequencer              ld
);
    localparam int ID_W   = $clog2(NUM_TRIANGLE);
    localparam int VTX_AW = $clog2(4 * NUM_TRIANGLE);
    localparam int CNT_W  = $clog2(NUM_TRIANGLE + 1);

    tri_pkg::load_state_e state;
    tri_pkg::load_beat_t  in_beat;
    tri_pkg::load_beat_t  beat_q;
    logic [1:0]           word_cnt;
    logic [CNT_W-1:0]     tri_cnt;
    logic [CNT_W-1:0]     tri_base;
    logic [VTX_AW-1:0]    vtx_cnt;
    logic                 accept;
    logic                 top_zero;
    logic                 idx_phase;

    assign in_beat   = data_mc;
    assign rdy_mc    = state != tri_pkg::ld_index_words;
    assign accept    = we_mc && rdy_mc;
    assign top_zero  = in_beat.w3 == '0;
    assign idx_phase = (state == tri_pkg::ld_idle) || (state == tri_pkg::ld_done);
    // a new beat after a finished load starts over at triangle 0
    assign tri_base  = (state == tri_pkg::ld_done) ? '0 : tri_cnt;

    always_comb begin
        ld.idx_we    = 1'b0;
        ld.idx_addr  = {tri_base[ID_W-1:0], tri_pkg::slot_v0};
        ld.idx_data  = in_beat.w0;
        ld.count_we  = 1'b0;
        ld.count_val = tri_base;
        ld.vtx_we    = accept && (state == tri_pkg::ld_vertex) && !top_zero;
        ld.vtx_addr  = vtx_cnt;
        ld.vtx_data  = '{x: in_beat.w0, y: in_beat.w1, z: in_beat.w2};
        if (state == tri_pkg::ld_index_words) begin
            // words 1..3 come from the held beat
            ld.idx_we   = 1'b1;
            ld.idx_addr = {tri_cnt[ID_W-1:0], word_cnt};
            case (word_cnt)
                2'd1:    ld.idx_data = beat_q.w1;
                2'd2:    ld.idx_data = beat_q.w2;
                default: ld.idx_data = beat_q.w3;
            endcase
        end else if (accept && idx_phase) begin
            // word 0 goes straight in, a zero top word closes the index phase
            ld.count_we = top_zero;
            ld.idx_we   = !top_zero;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= tri_pkg::ld_idle;
            word_cnt <= '0;
            tri_cnt  <= '0;
            vtx_cnt  <= '0;
        end else begin
            case (state)
                tri_pkg::ld_idle, tri_pkg::ld_done: begin
                    if (accept) begin
                        tri_cnt <= tri_base;
                        if (top_zero) begin
                            state   <= tri_pkg::ld_vertex;
                            vtx_cnt <= '0;
                        end else begin
                            state    <= tri_pkg::ld_index_words;
                            word_cnt <= 2'd1;
                        end
                    end
                end
                tri_pkg::ld_index_words: begin
                    word_cnt <= word_cnt + 2'd1;
                    if (word_cnt == 2'd3) begin
                        state   <= tri_pkg::ld_idle;
                        tri_cnt <= tri_cnt + 1'b1;
                    end
                end
                tri_pkg::ld_vertex: begin
                    if (accept) begin
                        if (top_zero) begin
                            state <= tri_pkg::ld_done;
                        end else begin
                            vtx_cnt <= vtx_cnt + 1'b1;
                        end
                    end
                end
                default: state <= tri_pkg::ld_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            beat_q <= in_beat;
        end
    end

    // the word walk must have wrapped before the next index beat is taken
    a_idx_beat_free: assert property (@(posedge clk) disable iff (!rst_n)
        (accept && idx_phase) |-> (word_cnt == 2'd0));

endmodule

// ==== index_store.sv ====
`timescale 1ns/1ps

module index_store #(
    parameter int NUM_TRIANGLE = 64
) (
    input  logic           clk,
    input  logic           rst_n,
    tri_load_if.index_side ld,
    tri_read_if.index_side rd
);
    localparam int IDX_AW = $clog2(4 * NUM_TRIANGLE);
    localparam int CNT_W  = $clog2(NUM_TRIANGLE + 1);

    logic [IDX_AW-1:0] ram_addr;
    logic [CNT_W-1:0]  count_q;

    // load owns the port while writing, reads never overlap a load
    assign ram_addr = ld.idx_we ? ld.idx_addr : {rd.idx_rd_id, rd.idx_rd_slot};

    // triangles in the current scene
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (ld.count_we) begin
            count_q <= ld.count_val;
        end
    end

    assign rd.tri_count = count_q;

    // four words per triangle: v0, v1, v2 indices then the surface id
    sp_ram #(
        .ADDR_W(IDX_AW),
        .DATA_W(tri_pkg::WORD_W)
    ) u_idx_ram (
        .clk  (clk),
        .we   (ld.idx_we),
        .addr (ram_addr),
        .wdata(ld.idx_data),
        .q    (rd.idx_word)
    );

endmodule

// ==== vertex_store.sv ====
`timescale 1ns/1ps

module vertex_store #(
    parameter int NUM_TRIANGLE = 64
) (
    input  logic            clk,
    tri_load_if.vertex_side ld,
    tri_read_if.vertex_side rd
);
    localparam int VTX_AW = $clog2(4 * NUM_TRIANGLE);

    logic [VTX_AW-1:0]          lane_addr;
    logic [tri_pkg::WORD_W-1:0] wr_lane [3];
    logic [tri_pkg::WORD_W-1:0] rd_lane [3];

    assign lane_addr = ld.vtx_we ? ld.vtx_addr : rd.vtx_rd_addr;

    // lane 0 is x, 1 is y, 2 is z
    assign wr_lane[0] = ld.vtx_data.x;
    assign wr_lane[1] = ld.vtx_data.y;
    assign wr_lane[2] = ld.vtx_data.z;

    for (genvar i = 0; i < 3; i++) begin : g_lane
        sp_ram #(
            .ADDR_W(VTX_AW),
            .DATA_W(tri_pkg::WORD_W)
        ) u_lane_ram (
            .clk  (clk),
            .we   (ld.vtx_we),
            .addr (lane_addr),
            .wdata(wr_lane[i]),
            .q    (rd_lane[i])
        );
    end

    assign rd.vtx_word = '{x: rd_lane[0], y: rd_lane[1], z: rd_lane[2]};

endmodule

// ==== triangle_fetch.sv ====
`timescale 1ns/1ps

module triangle_fetch #(
    parameter int NUM_TRIANGLE = 64
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              re_ic,
    input  logic [$clog2(NUM_TRIANGLE)-1:0]   triangle_id,
    output logic                              rdy_ic,
    output logic                              not_valid_ic,
    output tri_pkg::vertex_t                  vertex0_ic,
    output tri_pkg::vertex_t                  vertex1_ic,
    output tri_pkg::vertex_t                  vertex2_ic,
    output logic [tri_pkg::WORD_W-1:0]        sid_ic,
    tri_read_if.fetch                         rd
);
    localparam int ID_W   = $clog2(NUM_TRIANGLE);
    localparam int VTX_AW = $clog2(4 * NUM_TRIANGLE);
    localparam int CNT_W  = $clog2(NUM_TRIANGLE + 1);

    tri_pkg::fetch_state_e      state, state_d;
    logic [ID_W-1:0]            cur_id, cur_id_d;
    logic                       pf_active, pf_active_d;
    logic                       pf_valid, pf_valid_d;
    logic [CNT_W-1:0]           next_id;
    logic                       req_ok, req_bad, id_match, next_ok;
    logic                       in_walk, abort, claim;
    logic                       take_buf, take_walk;
    tri_pkg::vertex_t           buf_v0, buf_v1, buf_v2;
    logic [tri_pkg::WORD_W-1:0] buf_sid;

    // the one range check against the loaded triangle count
    assign req_ok   = re_ic && ({1'b0, triangle_id} < rd.tri_count);
    assign req_bad  = re_ic && !req_ok;
    assign id_match = triangle_id == cur_id;
    assign next_id  = {1'b0, cur_id} + 1'b1;
    assign next_ok  = next_id < rd.tri_count;
    assign in_walk  = state != tri_pkg::f_idle;
    // a request during a prefetch either takes it over or restarts the walk
    assign abort    = in_walk && pf_active && req_ok && !id_match;
    assign claim    = in_walk && pf_active && req_ok && id_match;

    always_comb begin
        state_d     = state;
        cur_id_d    = cur_id;
        pf_active_d = pf_active && !claim;
        pf_valid_d  = pf_valid;
        take_buf    = 1'b0;
        take_walk   = 1'b0;
        if (abort) begin
            cur_id_d    = triangle_id;
            pf_active_d = 1'b0;
            state_d     = tri_pkg::f_rd_v0;
        end else begin
            case (state)
                tri_pkg::f_idle: begin
                    if (req_ok && pf_valid && id_match) begin
                        take_buf = 1'b1;
                    end else if (req_ok) begin
                        cur_id_d   = triangle_id;
                        pf_valid_d = 1'b0;
                        state_d    = tri_pkg::f_rd_v0;
                    end
                end
                tri_pkg::f_rd_v0:  state_d = tri_pkg::f_rd_v1;
                tri_pkg::f_rd_v1:  state_d = tri_pkg::f_rd_v2;
                tri_pkg::f_rd_v2:  state_d = tri_pkg::f_rd_sid;
                tri_pkg::f_rd_sid: state_d = tri_pkg::f_finish;
                default: begin
                    // buffers now hold all of cur_id
                    pf_valid_d  = 1'b1;
                    pf_active_d = 1'b0;
                    state_d     = tri_pkg::f_idle;
                    take_walk   = !pf_active || claim;
                end
            endcase
            // after serving n, go after n+1 while it is in the scene
            if ((take_buf || take_walk) && next_ok) begin
                cur_id_d    = next_id[ID_W-1:0];
                pf_active_d = 1'b1;
                pf_valid_d  = 1'b0;
                state_d     = tri_pkg::f_rd_v0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= tri_pkg::f_idle;
            cur_id       <= '0;
            pf_active    <= 1'b0;
            pf_valid     <= 1'b0;
            rdy_ic       <= 1'b0;
            not_valid_ic <= 1'b0;
        end else begin
            state        <= state_d;
            cur_id       <= cur_id_d;
            pf_active    <= pf_active_d;
            pf_valid     <= pf_valid_d;
            rdy_ic       <= take_buf || take_walk;
            not_valid_ic <= req_bad;
        end
    end

    // index k+1 comes back while vertex k leaves the lanes
    always_comb begin
        case (state)
            tri_pkg::f_rd_v1:  rd.idx_rd_slot = tri_pkg::slot_v1;
            tri_pkg::f_rd_v2:  rd.idx_rd_slot = tri_pkg::slot_v2;
            tri_pkg::f_rd_sid: rd.idx_rd_slot = tri_pkg::slot_sid;
            default:           rd.idx_rd_slot = tri_pkg::slot_v0;
        endcase
    end

    assign rd.idx_rd_id   = cur_id;
    assign rd.vtx_rd_addr = rd.idx_word[VTX_AW-1:0];

    always_ff @(posedge clk) begin
        if (state == tri_pkg::f_rd_v2) begin
            buf_v0 <= rd.vtx_word;
        end
        if (state == tri_pkg::f_rd_sid) begin
            buf_v1 <= rd.vtx_word;
        end
        if (state == tri_pkg::f_finish) begin
            buf_v2  <= rd.vtx_word;
            buf_sid <= rd.idx_word;
        end
    end

    // outputs hold until the next result
    always_ff @(posedge clk) begin
        if (take_buf) begin
            vertex0_ic <= buf_v0;
            vertex1_ic <= buf_v1;
            vertex2_ic <= buf_v2;
            sid_ic     <= buf_sid;
        end else if (take_walk) begin
            // last vertex and sid are still on the RAM outputs
            vertex0_ic <= buf_v0;
            vertex1_ic <= buf_v1;
            vertex2_ic <= rd.vtx_word;
            sid_ic     <= rd.idx_word;
        end
    end

    // one outcome per request
    a_one_result: assert property (@(posedge clk) disable iff (!rst_n)
        !(rdy_ic && not_valid_ic));

endmodule

// ==== triangle_mem.sv ====
`timescale 1ns/1ps

module triangle_mem #(
    parameter int NUM_TRIANGLE = 64
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [tri_pkg::BEAT_W-1:0]          data_mc,
    input  logic                                we_mc,
    output logic                                rdy_mc,
    input  logic                                re_ic,
    input  logic [$clog2(NUM_TRIANGLE)-1:0]     triangle_id,
    output logic                                rdy_ic,
    output logic                                not_valid_ic,
    output logic [$bits(tri_pkg::vertex_t)-1:0] vertex0_ic,
    output logic [$bits(tri_pkg::vertex_t)-1:0] vertex1_ic,
    output logic [$bits(tri_pkg::vertex_t)-1:0] vertex2_ic,
    output logic [tri_pkg::WORD_W-1:0]          sid_ic
);
    tri_load_if #(.NUM_TRIANGLE(NUM_TRIANGLE)) ld_bus ();
    tri_read_if #(.NUM_TRIANGLE(NUM_TRIANGLE)) rd_bus ();

    load_sequencer #(.NUM_TRIANGLE(NUM_TRIANGLE)) u_load (
        .clk    (clk),
        .rst_n  (rst_n),
        .data_mc(data_mc),
        .we_mc  (we_mc),
        .rdy_mc (rdy_mc),
        .ld     (ld_bus.sequencer)
    );

    index_store #(.NUM_TRIANGLE(NUM_TRIANGLE)) u_index (
        .clk  (clk),
        .rst_n(rst_n),
        .ld   (ld_bus.index_side),
        .rd   (rd_bus.index_side)
    );

    vertex_store #(.NUM_TRIANGLE(NUM_TRIANGLE)) u_vertex (
        .clk(clk),
        .ld (ld_bus.vertex_side),
        .rd (rd_bus.vertex_side)
    );

    triangle_fetch #(.NUM_TRIANGLE(NUM_TRIANGLE)) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .re_ic       (re_ic),
        .triangle_id (triangle_id),
        .rdy_ic      (rdy_ic),
        .not_valid_ic(not_valid_ic),
        .vertex0_ic  (vertex0_ic),
        .vertex1_ic  (vertex1_ic),
        .vertex2_ic  (vertex2_ic),
        .sid_ic      (sid_ic),
        .rd          (rd_bus.fetch)
    );

endmodule

// ==== tb_triangle_mem.sv ====
`timescale 1ns/1ps

module tb_triangle_mem;

    localparam int NUM_TRIANGLE = 64;
    localparam int ID_W         = $clog2(NUM_TRIANGLE);
    localparam int SCENE_TRI    = 20;
    localparam int SCENE_VTX    = 30;
    localparam int LOAD_BEATS   = SCENE_TRI + SCENE_VTX + 2;
    localparam int NUM_READS    = 46;
    localparam int WATCHDOG_CYC = LOAD_BEATS * 5 + NUM_READS * 20 + 200;
    localparam int READ_LIMIT   = 30;

    logic                       clk;
    logic                       rst_n;
    logic [tri_pkg::BEAT_W-1:0] data_mc;
    logic                       we_mc;
    logic                       rdy_mc;
    logic                       re_ic;
    logic [ID_W-1:0]            triangle_id;
    logic                       rdy_ic;
    logic                       not_valid_ic;
    tri_pkg::vertex_t           vertex0_ic;
    tri_pkg::vertex_t           vertex1_ic;
    tri_pkg::vertex_t           vertex2_ic;
    logic [tri_pkg::WORD_W-1:0] sid_ic;

    logic [31:0]                seed;
    int                         errors;
    int                         checks;

    // reference scene
    tri_pkg::vertex_t           model_vtx [SCENE_VTX];
    int                         model_idx [SCENE_TRI][3];
    logic [tri_pkg::WORD_W-1:0] model_sid [SCENE_TRI];

    triangle_mem #(.NUM_TRIANGLE(NUM_TRIANGLE)) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_mc     (data_mc),
        .we_mc       (we_mc),
        .rdy_mc      (rdy_mc),
        .re_ic       (re_ic),
        .triangle_id (triangle_id),
        .rdy_ic      (rdy_ic),
        .not_valid_ic(not_valid_ic),
        .vertex0_ic  (vertex0_ic),
        .vertex1_ic  (vertex1_ic),
        .vertex2_ic  (vertex2_ic),
        .sid_ic      (sid_ic)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_vertex(input string name, input tri_pkg::vertex_t exp,
                                input tri_pkg::vertex_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_sid(input string name, input logic [tri_pkg::WORD_W-1:0] exp,
                             input logic [tri_pkg::WORD_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // inputs change 1 ns after the edge, outputs are sampled there too
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_beat(input tri_pkg::load_beat_t beat, input logic index_beat);
        int i;
        while (!rdy_mc) begin
            next_cycle();
        end
        data_mc = beat;
        we_mc   = 1'b1;
        next_cycle();
        we_mc   = 1'b0;
        // index beats keep the loader busy for words 1 to 3
        if (index_beat) begin
            for (i = 0; i < 3; i++) begin
                check_flag("index beat busy", 1'b0, rdy_mc);
                next_cycle();
            end
        end
        check_flag("loader ready", 1'b1, rdy_mc);
    endtask

    task automatic load_scene();
        tri_pkg::load_beat_t beat;
        logic [31:0]         word;
        int                  t;
        int                  k;
        for (t = 0; t < SCENE_TRI; t++) begin
            for (k = 0; k < 3; k++) begin
                model_idx[t][k] = next_rand() % SCENE_VTX;
            end
            word = next_rand();
            // a zero sid would end the index phase
            model_sid[t] = word | 32'h1;
            beat = '{w3: model_sid[t], w2: model_idx[t][2], w1: model_idx[t][1],
                     w0: model_idx[t][0]};
            send_beat(beat, 1'b1);
        end
        send_beat('0, 1'b0);
        for (k = 0; k < SCENE_VTX; k++) begin
            model_vtx[k].x = next_rand();
            model_vtx[k].y = next_rand();
            model_vtx[k].z = next_rand();
            beat = '{w3: 32'h1, w2: model_vtx[k].z, w1: model_vtx[k].y,
                     w0: model_vtx[k].x};
            send_beat(beat, 1'b0);
        end
        send_beat('0, 1'b0);
    endtask

    task automatic read_triangle(input string name, input int id, input logic in_range,
                                 input logic expect_hit);
        int wait_cyc;
        triangle_id = id[ID_W-1:0];
        re_ic       = 1'b1;
        next_cycle();
        re_ic       = 1'b0;
        wait_cyc    = 1;
        while (!rdy_ic && !not_valid_ic && wait_cyc < READ_LIMIT) begin
            next_cycle();
            wait_cyc++;
        end
        if (!rdy_ic && !not_valid_ic) begin
            errors++;
            $display("%s: triangle %0d got no response at all", name, id);
        end else if (!in_range) begin
            check_flag({name, " not_valid"}, 1'b1, not_valid_ic);
            check_flag({name, " one cycle"}, 1'b1, wait_cyc == 1);
            check_flag({name, " rdy_ic"}, 1'b0, rdy_ic);
            next_cycle();
            check_flag({name, " not_valid pulse"}, 1'b0, not_valid_ic);
            check_flag({name, " rdy_ic after"}, 1'b0, rdy_ic);
        end else begin
            check_flag({name, " rdy_ic"}, 1'b1, rdy_ic);
            check_flag({name, " not_valid"}, 1'b0, not_valid_ic);
            if (expect_hit) begin
                check_flag({name, " prefetch hit"}, 1'b1, wait_cyc == 1);
            end
            check_vertex({name, " v0"}, model_vtx[model_idx[id][0]], vertex0_ic);
            check_vertex({name, " v1"}, model_vtx[model_idx[id][1]], vertex1_ic);
            check_vertex({name, " v2"}, model_vtx[model_idx[id][2]], vertex2_ic);
            check_sid({name, " sid"}, model_sid[id], sid_ic);
        end
    endtask

    task automatic test_reset_state();
        check_flag("reset rdy_mc", 1'b1, rdy_mc);
        check_flag("reset rdy_ic", 1'b0, rdy_ic);
        check_flag("reset not_valid_ic", 1'b0, not_valid_ic);
        read_triangle("read before load", 0, 1'b0, 1'b0);
    endtask

    task automatic test_random_reads();
        int order [SCENE_TRI];
        int i;
        int j;
        int tmp;
        load_scene();
        for (i = 0; i < SCENE_TRI; i++) begin
            order[i] = i;
        end
        // shuffle the read order
        for (i = SCENE_TRI - 1; i > 0; i--) begin
            j        = next_rand() % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < SCENE_TRI; i++) begin
            read_triangle($sformatf("random read %0d", order[i]), order[i], 1'b1, 1'b0);
        end
    endtask

    task automatic test_sequential_hits();
        int id;
        read_triangle("sequential read 0", 0, 1'b1, 1'b0);
        for (id = 1; id < SCENE_TRI; id++) begin
            // leave time for the prefetch to fill the buffers
            repeat (8) next_cycle();
            read_triangle($sformatf("sequential read %0d", id), id, 1'b1, 1'b1);
        end
    endtask

    task automatic test_prefetch_abort();
        read_triangle("abort first read 5", 5, 1'b1, 1'b0);
        read_triangle("abort second read 12", 12, 1'b1, 1'b0);
    endtask

    task automatic test_out_of_range();
        read_triangle("range read 20", 20, 1'b0, 1'b0);
        read_triangle("range read 63", 63, 1'b0, 1'b0);
        read_triangle("range read 7 after", 7, 1'b1, 1'b0);
    endtask

    initial begin
        seed        = 32'h8208fc4c;
        errors      = 0;
        checks      = 0;
        rst_n       = 1'b0;
        data_mc     = '0;
        we_mc       = 1'b0;
        re_ic       = 1'b0;
        triangle_id = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        test_reset_state();
        test_random_reads();
        test_sequential_hits();
        test_prefetch_abort();
        test_out_of_range();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("watchdog: the tests did not finish within %0d cycles", WATCHDOG_CYC);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== flist.f ====
tri_pkg.sv
tri_load_if.sv
tri_read_if.sv
sp_ram.sv
load_sequencer.sv
index_store.sv
vertex_store.sv
triangle_fetch.sv
triangle_mem.sv
tb_triangle_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_triangle_mem -f flist.f -o tb_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/tb_sim 2>&1); then
    echo "$sim_out"
    echo "simulation did not run to completion"
    exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
